//--- logic/fe_defines.svh
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// pc held in reset, one word below the boot address
// so the first sequential step lands on boot
`define FE_RESET_PC 32'h1bfffffc

// first instruction fetched after reset
`define FE_BOOT_PC 32'h1c000000

// major opcodes, bits [31:26] of the instruction word
// unconditional branch
`define FE_OP_B 6'b010100
// branch and link, writes the return address to r1
`define FE_OP_BL 6'b010101

// link register number written by bl
`define FE_LINK_REG 5'd1

// one-hot exception bus along the pipeline
// width of the bus
`define FE_EBUS_W 16
// instruction address error, fetch pc not word aligned
`define FE_EBUS_ADEF 8

`endif

//--- logic/fe_pkg.sv
`default_nettype none

package fe_pkg;

    // i26 form, used by b and bl
    // offset is split, low half sits above the high half
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fe_i26_t;

    // 2ri16 form, used for everything else in decode
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] imm16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fe_2ri16_t;

    // one instruction word, two overlapping views
    // opcode field lines up in both
    typedef union packed {
        fe_i26_t   i26;
        fe_2ri16_t ri16;
    } fe_inst_t;

    // what decode resolved the instruction to
    // only b and bl are acted on here
    typedef enum logic [1:0] {
        op_b     = 2'd0,
        op_bl    = 2'd1,
        op_other = 2'd2
    } fe_op_e;

endpackage

`default_nettype wire

//--- logic/fe_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

// fetch to decode bundle
// a transfer happens when valid and allow_in are both high
interface fe_stage_if
    import fe_pkg::*;
();

    // fetch has an instruction to hand over
    logic                    valid;
    // decode can take it this cycle
    logic                    allow_in;
    // pc paired with the instruction
    logic [31:0]             pc;
    // raw word from the sram
    fe_inst_t                inst;
    // one-hot exceptions raised so far
    logic [`FE_EBUS_W-1:0]   ebus;

    modport fetch (
        output valid,
        output pc,
        output inst,
        output ebus,
        input  allow_in
    );

    modport decode (
        input  valid,
        input  pc,
        input  inst,
        input  ebus,
        output allow_in
    );

endinterface

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module fetch_stage (
    input  logic         clk,
    input  logic         reset,

    // bundle to decode
    fe_stage_if.fetch    fs,

    // redirect from decode
    input  logic         br_taken,
    input  logic [31:0]  br_target,

    // later-stage flush
    input  logic         except_valid,
    input  logic         wb_ex,
    input  logic         ertn_flush,
    input  logic [31:0]  ex_entry,
    input  logic [31:0]  era_pc,

    // instruction sram
    output logic         inst_sram_en,
    output logic [31:0]  inst_sram_addr,
    input  logic [31:0]  inst_sram_rdata
);

    // pc of the word currently returned by the sram
    logic [31:0] pc;
    logic [31:0] pc_seq;
    logic [31:0] next_pc;

    // flush kinds, qualified by except_valid
    logic        ertn_go;
    logic        ex_go;

    // pc advances and a new sram read is issued
    logic        fetch_go;

    // set one cycle after reset, then stays
    logic        fs_valid_q;

    // misalignment of the pc now being fetched
    logic        adef_q;

    assign ertn_go = except_valid & ertn_flush;
    assign ex_go   = except_valid & wb_ex;

    assign pc_seq = pc + 32'd4;

    // next pc, ertn beats exception beats branch
    always_comb
    begin
        if (ertn_go)
        begin
            next_pc = era_pc;
        end
        else if (ex_go)
        begin
            next_pc = ex_entry;
        end
        else if (br_taken)
        begin
            next_pc = br_target;
        end
        else
        begin
            next_pc = pc_seq;
        end
    end

    // flush restarts fetch even while decode is stalled
    assign fetch_go = (fs.allow_in & ~reset) | ertn_go | ex_go;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= `FE_RESET_PC;
        end
        else if (fetch_go)
        begin
            pc <= next_pc;
        end
    end

    // adef is captured with the address so it follows its own word
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            adef_q <= 1'b0;
        end
        else if (fetch_go)
        begin
            adef_q <= (next_pc[1:0] != 2'b00);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fs_valid_q <= 1'b0;
        end
        else
        begin
            fs_valid_q <= 1'b1;
        end
    end

    // sram is read at next_pc; data held while en is low
    assign inst_sram_en   = fetch_go;
    assign inst_sram_addr = next_pc;

    // only adef can be raised this early
    always_comb
    begin
        fs.ebus                = '0;
        fs.ebus[`FE_EBUS_ADEF] = adef_q & fs_valid_q;
    end

    // word after a taken branch is the wrong path
    assign fs.valid = fs_valid_q & ~br_taken;
    assign fs.pc    = pc;
    assign fs.inst  = inst_sram_rdata;

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module decode_stage
    import fe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // bundle from fetch
    fe_stage_if.decode   ds,

    // later-stage flush, exception or ertn
    input  logic         flush,

    // redirect to fetch
    output logic         br_taken,
    output logic [31:0]  br_target,

    // consumer handshake
    input  logic         es_allow_in,

    // decoded instruction
    output logic         ds_valid,
    output logic [31:0]  ds_pc,
    output logic [31:0]  ds_inst,
    output fe_op_e       ds_op,
    output logic [4:0]   ds_rd,
    output logic [4:0]   ds_rj,
    output logic [15:0]  ds_imm,
    output logic         ds_adef
);

    // decode entry
    logic        valid_q;
    logic [31:0] pc_q;
    fe_inst_t    inst_q;
    logic        adef_q;

    fe_op_e      op;
    logic        is_branch;
    logic        accept;

    // sign-extended word offset of b and bl
    logic [31:0] br_offs;

    // one-cycle decode, so ready as soon as the entry drains
    assign ds.allow_in = ~valid_q | es_allow_in;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
        end
        else if (flush)
        begin
            // everything in flight is dropped
            valid_q <= 1'b0;
        end
        else if (ds.allow_in)
        begin
            valid_q <= ds.valid;
        end
    end

    // payload only loads on a real transfer
    always_ff @(posedge clk)
    begin
        if (ds.valid && ds.allow_in)
        begin
            pc_q   <= ds.pc;
            inst_q <= ds.inst;
            adef_q <= ds.ebus[`FE_EBUS_ADEF];
        end
    end

    // major opcode is the same field in both views
    always_comb
    begin
        case (inst_q.i26.opcode)
            `FE_OP_B:  op = op_b;
            `FE_OP_BL: op = op_bl;
            default:   op = op_other;
        endcase
    end

    assign is_branch = (op == op_b) || (op == op_bl);
    assign accept    = valid_q & es_allow_in;

    // offs[25:16] sits in the low bits of the word
    assign br_offs = {{4{inst_q.i26.offs_hi[9]}}, inst_q.i26.offs_hi,
                      inst_q.i26.offs_lo, 2'b00};

    assign br_target = pc_q + br_offs;

    // pulse only when the branch leaves decode, so it fires once
    assign br_taken = accept & is_branch;

    // register fields
    always_comb
    begin
        ds_rd  = 5'd0;
        ds_rj  = 5'd0;
        ds_imm = 16'd0;
        case (op)
            op_bl:
            begin
                // return address goes to r1
                ds_rd = `FE_LINK_REG;
            end
            op_other:
            begin
                ds_rd  = inst_q.ri16.rd;
                ds_rj  = inst_q.ri16.rj;
                ds_imm = inst_q.ri16.imm16;
            end
            default:
            begin
                ds_rd = 5'd0;
            end
        endcase
    end

    assign ds_valid = valid_q;
    assign ds_pc    = pc_q;
    assign ds_inst  = inst_q;
    assign ds_op    = op;
    assign ds_adef  = adef_q;

endmodule

`default_nettype wire

//--- logic/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import fe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // instruction sram
    output logic         inst_sram_en,
    output logic [31:0]  inst_sram_addr,
    input  logic [31:0]  inst_sram_rdata,

    // flush from writeback
    input  logic         except_valid,
    input  logic         wb_ex,
    input  logic [31:0]  ex_entry,
    input  logic         ertn_flush,
    input  logic [31:0]  era_pc,

    // consumer
    input  logic         es_allow_in,
    output logic         ds_valid,
    output logic [31:0]  ds_pc,
    output logic [31:0]  ds_inst,
    output fe_op_e       ds_op,
    output logic [4:0]   ds_rd,
    output logic [4:0]   ds_rj,
    output logic [15:0]  ds_imm,
    output logic         ds_adef
);

    // either flush kind empties decode
    logic        flush;

    // branch bus, decode to fetch
    logic        br_taken;
    logic [31:0] br_target;

    fe_stage_if fs_if ();

    assign flush = except_valid & (wb_ex | ertn_flush);

    fetch_stage fetch_i (
        .clk             (clk),
        .reset           (reset),
        .fs              (fs_if.fetch),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .except_valid    (except_valid),
        .wb_ex           (wb_ex),
        .ertn_flush      (ertn_flush),
        .ex_entry        (ex_entry),
        .era_pc          (era_pc),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata)
    );

    decode_stage decode_i (
        .clk         (clk),
        .reset       (reset),
        .ds          (fs_if.decode),
        .flush       (flush),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .es_allow_in (es_allow_in),
        .ds_valid    (ds_valid),
        .ds_pc       (ds_pc),
        .ds_inst     (ds_inst),
        .ds_op       (ds_op),
        .ds_rd       (ds_rd),
        .ds_rj       (ds_rj),
        .ds_imm      (ds_imm),
        .ds_adef     (ds_adef)
    );

endmodule

`default_nettype wire

//--- tests/frontend_assert.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_assert (
    input  logic         clk,
    input  logic         reset,
    input  logic         inst_sram_en,
    input  logic         except_valid,
    input  logic         wb_ex,
    input  logic         ertn_flush,
    input  logic         es_allow_in,
    input  logic         ds_valid,
    input  logic [31:0]  ds_pc,
    input  logic [31:0]  ds_inst
);

    int   fail_count = 0;
    logic flush;

    assign flush = except_valid & (wb_ex | ertn_flush);

    // no sram read while held in reset
    sram_idle_in_reset: assert property (@(posedge clk) reset |-> !inst_sram_en)
        else
        begin
            fail_count++;
            $error("inst_sram_en high during reset");
        end

    // decode comes out of reset empty
    ds_empty_after_reset: assert property (@(posedge clk) reset |=> !ds_valid)
        else
        begin
            fail_count++;
            $error("ds_valid high right after reset");
        end

    // stalled output held unchanged until taken
    ds_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !es_allow_in && !flush |=> ds_valid && $stable(ds_pc) && $stable(ds_inst))
        else
        begin
            fail_count++;
            $error("decode output changed while es_allow_in was low");
        end

endmodule

`default_nettype wire

//--- tests/frontend_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module frontend_checker
    import fe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         except_valid,
    input  logic         wb_ex,
    input  logic         ertn_flush,
    input  logic [31:0]  ex_entry,
    input  logic [31:0]  era_pc,
    input  logic         es_allow_in,
    input  logic         ds_valid,
    input  logic [31:0]  ds_pc,
    input  logic [31:0]  ds_inst,
    input  fe_op_e       ds_op,
    input  logic [4:0]   ds_rd,
    input  logic [4:0]   ds_rj,
    input  logic [15:0]  ds_imm,
    input  logic         ds_adef
);

    // own copy of the program image
    logic [31:0] image [logic [31:0]];
    // pc the next accepted output must carry
    logic [31:0] exp_pc = `FE_BOOT_PC;
    int          error_count = 0;
    int          accept_count = 0;

    task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
        image[addr] = word;
    endtask

    // sram ignores the low address bits, unwritten words read zero
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        if (image.exists(base))
        begin
            return image[base];
        end
        return 32'd0;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk)
    begin : watch_outputs
        logic [31:0] inst;
        logic [5:0]  opcode;
        logic [25:0] offs;
        logic [31:0] next_pc;
        fe_op_e      exp_op;
        logic [4:0]  exp_rd;
        logic [4:0]  exp_rj;
        logic [15:0] exp_imm;
        if (reset)
        begin
            exp_pc = `FE_BOOT_PC;
        end
        else if (except_valid && (wb_ex || ertn_flush))
        begin
            if (ds_valid && es_allow_in)
            begin
                error_count++;
                $display("an output was accepted in a flush cycle at t=%0t", $time);
            end
            // ertn target beats exception entry
            exp_pc = ertn_flush ? era_pc : ex_entry;
        end
        else if (ds_valid && es_allow_in)
        begin
            accept_count++;
            inst    = word_at(exp_pc);
            opcode  = inst[31:26];
            // i26 offset, high ten bits sit at the bottom of the word
            offs    = {inst[9:0], inst[25:10]};
            next_pc = exp_pc + 32'd4;
            exp_op  = op_other;
            exp_rd  = inst[4:0];
            exp_rj  = inst[9:5];
            exp_imm = inst[25:10];
            if (opcode == `FE_OP_B || opcode == `FE_OP_BL)
            begin
                if (opcode == `FE_OP_B)
                begin
                    exp_op = op_b;
                    exp_rd = 5'd0;
                end
                else
                begin
                    exp_op = op_bl;
                    // link register
                    exp_rd = 5'd1;
                end
                exp_rj  = 5'd0;
                exp_imm = 16'd0;
                next_pc = exp_pc + {{4{offs[25]}}, offs, 2'b00};
            end
            compare_field("ds_pc", ds_pc, exp_pc);
            compare_field("ds_inst", ds_inst, inst);
            compare_field("ds_op", {30'd0, ds_op}, {30'd0, exp_op});
            compare_field("ds_rd", {27'd0, ds_rd}, {27'd0, exp_rd});
            compare_field("ds_rj", {27'd0, ds_rj}, {27'd0, exp_rj});
            compare_field("ds_imm", {16'd0, ds_imm}, {16'd0, exp_imm});
            compare_field("ds_adef", {31'd0, ds_adef}, {31'd0, exp_pc[1:0] != 2'b00});
            exp_pc = next_pc;
        end
    end

endmodule

`default_nettype wire

//--- tests/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb
    import fe_pkg::*;
();

    localparam int RUN_LIMIT = 5000;

    logic        clk = 1'b0;
    logic        reset;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        except_valid;
    logic        wb_ex;
    logic [31:0] ex_entry;
    logic        ertn_flush;
    logic [31:0] era_pc;
    logic        es_allow_in;
    logic        ds_valid;
    logic [31:0] ds_pc;
    logic [31:0] ds_inst;
    fe_op_e      ds_op;
    logic [4:0]  ds_rd;
    logic [4:0]  ds_rj;
    logic [15:0] ds_imm;
    logic        ds_adef;

    // program image and flush events from the data file
    logic [31:0] image [logic [31:0]];
    int          ev_count[$];
    logic [1:0]  ev_kind[$];
    logic [31:0] ev_entry[$];
    logic [31:0] ev_era[$];
    int          total_expected = 0;

    int          accepted = 0;
    int          tb_errors = 0;
    logic [31:0] lfsr = 32'h5db2bc19;

    // sram request seen at the last rising edge
    logic        rd_pending = 1'b0;
    logic [31:0] rd_addr = 32'd0;

    always #5 clk = ~clk;

    frontend_top dut_i (.*);

    frontend_checker check_i (.*);

    bind frontend_top frontend_assert assert_i (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] sram_word(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        if (image.exists(base))
        begin
            return image[base];
        end
        return 32'd0;
    endfunction

    // ready about three cycles in four
    task automatic draw_ready();
        logic b0;
        logic b1;
        lfsr = lfsr_next(lfsr);
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        es_allow_in = b0 | b1;
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        int          cnt;
        logic [7:0]  tag;
        logic [1:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        string       line;
        fd = $fopen("tests/frontend_tests.dat", "r");
        if (fd == 0)
        begin
            tb_errors++;
            $display("could not open tests/frontend_tests.dat");
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0)
            begin
                n = $sscanf(line, "%c", tag);
                case (tag)
                    "M":
                    begin
                        n = $sscanf(line, "%c %h %h", tag, a, b);
                        image[a] = b;
                        check_i.load_word(a, b);
                    end
                    "E":
                    begin
                        n = $sscanf(line, "%c %d %d %h %h", tag, cnt, kind, a, b);
                        ev_count.push_back(cnt);
                        ev_kind.push_back(kind);
                        ev_entry.push_back(a);
                        ev_era.push_back(b);
                    end
                    "N":
                    begin
                        n = $sscanf(line, "%c %d", tag, total_expected);
                    end
                    default:
                    begin
                        // comment or blank line
                    end
                endcase
            end
        end
        $fclose(fd);
        if (total_expected == 0)
        begin
            tb_errors++;
            $display("data file gives no count of expected outputs");
        end
    endtask

    // decode is stalled, so the flush only has to beat fetch
    task automatic pulse_flush(input int idx);
        es_allow_in  = 1'b0;
        except_valid = 1'b1;
        wb_ex        = ev_kind[idx][0];
        ertn_flush   = ev_kind[idx][1];
        ex_entry     = ev_entry[idx];
        era_pc       = ev_era[idx];
        @(negedge clk);
        except_valid = 1'b0;
        wb_ex        = 1'b0;
        ertn_flush   = 1'b0;
        draw_ready();
    endtask

    // sram answers in the cycle after the enable and holds otherwise
    always @(posedge clk)
    begin
        rd_pending <= inst_sram_en;
        rd_addr    <= inst_sram_addr;
    end

    always @(negedge clk)
    begin
        if (rd_pending)
        begin
            inst_sram_rdata <= sram_word(rd_addr);
        end
    end

    always @(posedge clk)
    begin
        if (!reset && ds_valid && es_allow_in)
        begin
            accepted++;
        end
    end

    initial
    begin : stimulus
        int  cycles;
        int  ev;
        int  errors;
        bit  done;
        reset           = 1'b1;
        es_allow_in     = 1'b0;
        except_valid    = 1'b0;
        wb_ex           = 1'b0;
        ertn_flush      = 1'b0;
        ex_entry        = 32'd0;
        era_pc          = 32'd0;
        inst_sram_rdata = 32'd0;
        cycles          = 0;
        ev              = 0;
        done            = 1'b0;
        load_tests();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            if (accepted >= total_expected)
            begin
                done = 1'b1;
            end
            else if (cycles > RUN_LIMIT)
            begin
                tb_errors++;
                $display("timeout after %0d of %0d outputs", accepted, total_expected);
                done = 1'b1;
            end
            else if (ev < ev_count.size() && accepted == ev_count[ev])
            begin
                pulse_flush(ev);
                ev++;
            end
            else
            begin
                draw_ready();
            end
        end
        es_allow_in = 1'b0;
        // short drain, nothing more may come out
        repeat (4) @(negedge clk);
        if (accepted != total_expected || check_i.accept_count != total_expected)
        begin
            tb_errors++;
            $display("accepted %0d outputs, checker saw %0d, expected %0d",
                     accepted, check_i.accept_count, total_expected);
        end
        errors = tb_errors + check_i.error_count + dut_i.assert_i.fail_count;
        $display("errors: checker %0d, assertions %0d, testbench %0d",
                 check_i.error_count, dut_i.assert_i.fail_count, tb_errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/frontend_tests.dat
# M <address hex> <word hex>
# E <accepted outputs before flush, dec> <kind 1 ex, 2 ertn, 3 both> <ex_entry hex> <era_pc hex>
# N <total accepted outputs, dec>
M 1c000000 02c00421
M 1c000004 03801c83
M 1c000008 2a4010a4
M 1c00000c 50001400
M 1c000010 0badf00d
M 1c000014 12345678
M 1c000018 00400000
M 1c00001c 50002400
M 1c000020 02800c0c
M 1c000024 57fff3ff
M 1c000028 0badf00d
M 1c000040 3c00a0e5
M 1c000044 00102345
M 1c000100 0c000001
M 1c000104 0c000002
M 1c000108 53fffbff
M 1c00010c 0badf00d
M 1c000200 0de0beef
M 1c000204 01234567
M 1c000300 0badf00d
M 1c000400 00ff00ff
M 1c000404 54000800
M 1c000408 0badf00d
M 1c00040c 02030405
E 12 1 1c000100 00000000
E 20 2 00000000 1c000202
E 24 3 1c000300 1c000400
N 32

//--- tb.f
+incdir+logic
logic/fe_pkg.sv
logic/fe_stage_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/frontend_top.sv
tests/frontend_assert.sv
tests/frontend_checker.sv
tests/frontend_tb.sv
